/* Makefile */
# Verilator build and run of the msadc testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module msadc_tb -o Vmsadc_tb

run: build
	./obj_dir/Vmsadc_tb | tee $(LOG)
	grep -q "No errors" $(LOG)

lint:
	verilator --lint-only --timing --assert -f files.f --top-module msadc_tb

clean:
	rm -rf obj_dir $(LOG)

/* files.f */
+incdir+hw
hw/msadc_pkg.sv
hw/msadc_modulator.sv
hw/msadc_spi_slave.sv
hw/msadc_reg_bank.sv
hw/msadc_top.sv
verification/msadc_props.sv
verification/msadc_tb.sv

/* hw/msadc_modulator.sv */
////////////////////////////////////////
// no back-pressure, an unread snapshot is overwritten
// cmp_out is asynchronous, 1 means integrator below zero cross
////////////////////////////////////////
`default_nettype none

`include "msadc_settings.svh"

module msadc_modulator
  import msadc_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         cmp_out,
  output int_sel_e     int_sel,
  output logic         cmp_latch,
  output logic         irq_n,
  output conv_result_t result
);

  localparam count_t INIT_CLKS  = count_t'(`MSADC_INIT_CLKS);
  localparam count_t FIX_CLKS   = count_t'(`MSADC_FIX_CLKS);
  localparam count_t VAR_CLKS   = count_t'(`MSADC_VAR_CLKS);
  // cycle count value seen at the end of the last regular VAR2
  localparam count_t LAST_CYCLE = count_t'(`MSADC_INT_CYCLES - 1);

  phase_e   state;
  count_t   clk_cnt;
  count_t   cycle_cnt;
  logic     flip;

  // live counts of the running conversion
  count_t   up_cnt;
  count_t   down_cnt;
  count_t   trans_up_cnt;
  count_t   trans_down_cnt;

  logic [2:0] cmp_q;
  logic     cmp_below;
  logic     cmp_edge;

  logic     conv_start;
  logic     var_start;
  logic     rundown_end;
  logic     sel_load;
  int_sel_e sel_new;

  ////////////////////////////////////////
  // comparator sync and edge detect

  always_ff @(posedge clk)
  begin
    cmp_q <= {cmp_q[1:0], cmp_out};
  end

  assign cmp_below = cmp_q[1];
  // either direction ends the rundown
  assign cmp_edge  = cmp_q[2] ^ cmp_q[1];

  assign conv_start  = (state == INIT) && (clk_cnt == INIT_CLKS);
  assign var_start   = (state == VAR_START) || (state == VAR2_START);
  assign rundown_end = (state == RUNDOWN) && cmp_edge;

  ////////////////////////////////////////
  // phase sequencer

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= INIT;
      clk_cnt   <= '0;
      cycle_cnt <= '0;
      flip      <= 1'b0;
      irq_n     <= 1'b1;
      cmp_latch <= 1'b1;
    end
    else
    begin
      // phase clock always runs, start states clear it
      clk_cnt <= clk_cnt + 1'b1;
      case (state)
        INIT:
          if (conv_start)
          begin
            state     <= FIX_POS_START;
            cycle_cnt <= '0;
            flip      <= 1'b0;
            // comparator enabled from first conversion on
            cmp_latch <= 1'b0;
          end
        FIX_POS_START:
        begin
          state   <= FIX_POS;
          clk_cnt <= '0;
        end
        FIX_POS:
          if (clk_cnt == FIX_CLKS)
            state <= VAR_START;
        VAR_START:
        begin
          state   <= VAR;
          clk_cnt <= '0;
        end
        VAR:
          if (clk_cnt == VAR_CLKS)
            state <= FIX_NEG_START;
        FIX_NEG_START:
        begin
          state   <= FIX_NEG;
          clk_cnt <= '0;
        end
        FIX_NEG:
          if (clk_cnt == FIX_CLKS)
            state <= VAR2_START;
        VAR2_START:
        begin
          state   <= VAR2;
          clk_cnt <= '0;
        end
        VAR2:
          if (clk_cnt == VAR_CLKS)
          begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (cycle_cnt >= LAST_CYCLE)
            begin
              // must end above zero cross for the rundown
              if (!cmp_below)
                state <= RUNDOWN_START;
              else
              begin
                flip  <= 1'b1;
                state <= VAR2_START;
              end
            end
            else
              state <= FIX_POS_START;
          end
        RUNDOWN_START:
        begin
          state   <= RUNDOWN;
          clk_cnt <= '0;
        end
        RUNDOWN:
          if (cmp_edge)
          begin
            state <= DONE;
            irq_n <= 1'b0;
          end
        DONE:
        begin
          // single clock interrupt pulse
          irq_n   <= 1'b1;
          state   <= INIT;
          clk_cnt <= '0;
        end
        default:
          state <= INIT;
      endcase
    end
  end

  ////////////////////////////////////////
  // integrator switch selection

  always_comb
  begin
    sel_load = 1'b0;
    sel_new  = SEL_NONE;
    case (state)
      FIX_POS_START:
      begin
        sel_load = 1'b1;
        sel_new  = SEL_POS;
      end
      VAR_START, VAR2_START:
      begin
        // drive towards the zero cross
        sel_load = 1'b1;
        sel_new  = cmp_below ? SEL_NEG : SEL_POS;
      end
      FIX_NEG_START:
      begin
        sel_load = 1'b1;
        sel_new  = SEL_NEG;
      end
      RUNDOWN_START:
      begin
        sel_load = 1'b1;
        sel_new  = SEL_BOTH;
      end
      RUNDOWN:
        sel_load = cmp_edge;
      default:
        sel_load = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      int_sel <= SEL_NONE;
    else if (sel_load)
      int_sel <= sel_new;
  end

  // up/down phases and reference transitions
  always_ff @(posedge clk)
  begin
    if (conv_start)
    begin
      up_cnt         <= '0;
      down_cnt       <= '0;
      trans_up_cnt   <= '0;
      trans_down_cnt <= '0;
    end
    else
    begin
      if (var_start)
      begin
        if (sel_new == SEL_NEG)
          up_cnt <= up_cnt + 1'b1;
        else
          down_cnt <= down_cnt + 1'b1;
      end
      // count only real changes of direction
      if (sel_load && (sel_new != int_sel))
      begin
        case (sel_new)
          SEL_NEG: trans_up_cnt <= trans_up_cnt + 1'b1;
          SEL_POS: trans_down_cnt <= trans_down_cnt + 1'b1;
          default: trans_up_cnt <= trans_up_cnt;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // result snapshot at rundown end

  always_ff @(posedge clk)
  begin
    if (rst)
      result <= '0;
    else if (rundown_end)
      result <= '{
        up:         up_cnt,
        down:       down_cnt,
        rundown:    clk_cnt,
        trans_up:   trans_up_cnt,
        trans_down: trans_down_cnt,
        flip:       flip
      };
  end

endmodule

`default_nettype wire

/* hw/msadc_pkg.sv */
////////////////////////////////////////
// counts and register values are 24 bit, addresses 8 bit
////////////////////////////////////////
`default_nettype none

package msadc_pkg;

  // phase, transition or clock count
  typedef logic [23:0] count_t;
  // spi address byte, top bit marks a read-only frame
  typedef logic [7:0] reg_addr_t;
  typedef logic [23:0] reg_data_t;

  // integrator switches as {signal, negative ref, positive ref}
  typedef enum logic [2:0] {
    SEL_NONE = 3'b000,
    // positive ref drives the integrator down
    SEL_POS  = 3'b001,
    // negative ref drives it up
    SEL_NEG  = 3'b010,
    // both refs on for the slow rundown
    SEL_BOTH = 3'b011
  } int_sel_e;

  // modulator phases, each run phase has a one clock start state
  typedef enum logic [3:0] {
    INIT,
    FIX_POS_START,
    FIX_POS,
    VAR_START,
    VAR,
    FIX_NEG_START,
    FIX_NEG,
    VAR2_START,
    VAR2,
    RUNDOWN_START,
    RUNDOWN,
    DONE
  } phase_e;

  // snapshot of one finished conversion
  typedef struct packed {
    count_t up;
    count_t down;
    count_t rundown;
    count_t trans_up;
    count_t trans_down;
    logic   flip;
  } conv_result_t;

  // write command from the spi side
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    reg_data_t data;
  } reg_wr_t;

endpackage

`default_nettype wire

/* hw/msadc_reg_bank.sv */
////////////////////////////////////////
// reads decode the low 7 address bits, one clk reply latency
////////////////////////////////////////
`default_nettype none

`include "msadc_settings.svh"

module msadc_reg_bank
  import msadc_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  conv_result_t result,
  input  logic         rd_req,
  input  reg_addr_t    rd_addr,
  output reg_data_t    rd_data,
  input  reg_wr_t      wr
);

  // write address compared in full, spi side clears valid on read-only frames
  localparam reg_addr_t  WR_TEST      = reg_addr_t'(`MSADC_ADDR_TEST);

  localparam logic [6:0] A_TEST       = 7'(`MSADC_ADDR_TEST);
  localparam logic [6:0] A_UP         = 7'(`MSADC_ADDR_UP);
  localparam logic [6:0] A_DOWN       = 7'(`MSADC_ADDR_DOWN);
  localparam logic [6:0] A_RUNDOWN    = 7'(`MSADC_ADDR_RUNDOWN);
  localparam logic [6:0] A_TRANS_UP   = 7'(`MSADC_ADDR_TRANS_UP);
  localparam logic [6:0] A_TRANS_DOWN = 7'(`MSADC_ADDR_TRANS_DOWN);
  localparam logic [6:0] A_ONES       = 7'(`MSADC_ADDR_ONES);
  localparam logic [6:0] A_FLIP       = 7'(`MSADC_ADDR_FLIP);

  reg_data_t test_reg;

  ////////////////////////////////////////
  // test register

  always_ff @(posedge clk)
  begin
    if (rst)
      test_reg <= '0;
    else if (wr.valid && (wr.addr == WR_TEST))
      test_reg <= wr.data;
  end

  ////////////////////////////////////////
  // read decode, bit 7 is the no-write flag and ignored here

  always_ff @(posedge clk)
  begin
    if (rd_req)
    begin
      case (rd_addr[6:0])
        A_TEST:       rd_data <= test_reg;
        A_UP:         rd_data <= result.up;
        A_DOWN:       rd_data <= result.down;
        A_RUNDOWN:    rd_data <= result.rundown;
        A_TRANS_UP:   rd_data <= result.trans_up;
        A_TRANS_DOWN: rd_data <= result.trans_down;
        // fixed pattern for link checks
        A_ONES:       rd_data <= '1;
        // flip in bit 0
        A_FLIP:       rd_data <= reg_data_t'(result.flip);
        default:      rd_data <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/msadc_settings.svh */
////////////////////////////////////////
// all timing in clk units, init time sized for simulation
// scale MSADC_INIT_CLKS up for hardware to allow spi readout
////////////////////////////////////////
`ifndef MSADC_SETTINGS_SVH
`define MSADC_SETTINGS_SVH

// idle clocks before each conversion
`define MSADC_INIT_CLKS 50
// fixed and variable phase lengths
`define MSADC_FIX_CLKS 10
`define MSADC_VAR_CLKS 70
// full four-phase cycles per integration
`define MSADC_INT_CYCLES 4
// one cycle incl. the start states and phase end clocks
`define MSADC_CYCLE_CLKS (2 * (`MSADC_FIX_CLKS + `MSADC_VAR_CLKS) + 8)

// register map, spi address space
`define MSADC_ADDR_TEST 7
`define MSADC_ADDR_UP 9
`define MSADC_ADDR_DOWN 10
`define MSADC_ADDR_RUNDOWN 11
`define MSADC_ADDR_TRANS_UP 12
`define MSADC_ADDR_TRANS_DOWN 14
`define MSADC_ADDR_ONES 15
`define MSADC_ADDR_FLIP 17

// address bit that turns a frame into a pure read
`define MSADC_NO_WRITE_BIT 7

`endif

/* hw/msadc_spi_slave.sv */
////////////////////////////////////////
// sclk half-period at least 4 clk, sclk idles low
// frames of exactly 32 bits write, shorter or longer are dropped
////////////////////////////////////////
`default_nettype none

`include "msadc_settings.svh"

module msadc_spi_slave
  import msadc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      spi_cs,
  input  logic      spi_sclk,
  input  logic      spi_mosi,
  output logic      spi_miso,
  output logic      rd_req,
  output reg_addr_t rd_addr,
  input  reg_data_t rd_data,
  output reg_wr_t   wr
);

  localparam logic [5:0] ADDR_LAST  = 6'd7;
  localparam logic [5:0] FRAME_BITS = 6'd32;
  localparam logic [5:0] CNT_MAX    = 6'h3f;
  // no-write flag position inside the received frame
  localparam int         NO_WR_POS  = 24 + `MSADC_NO_WRITE_BIT;

  logic [2:0]  cs_q;
  logic [2:0]  sclk_q;
  logic [1:0]  mosi_q;
  logic        cs_low;
  logic        cs_fall;
  logic        cs_rise;
  logic        sclk_fall;
  logic [5:0]  bit_cnt;
  logic [31:0] shift_in;
  reg_data_t   shift_out;
  logic        load_pend;

  ////////////////////////////////////////
  // pin sync, mosi stays aligned with sclk

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cs_q   <= '1;
      sclk_q <= '0;
    end
    else
    begin
      cs_q   <= {cs_q[1:0], spi_cs};
      sclk_q <= {sclk_q[1:0], spi_sclk};
    end
  end

  always_ff @(posedge clk)
  begin
    mosi_q <= {mosi_q[0], spi_mosi};
  end

  assign cs_low    = ~cs_q[1];
  assign cs_fall   = cs_q[2] & ~cs_q[1];
  assign cs_rise   = ~cs_q[2] & cs_q[1];
  assign sclk_fall = sclk_q[2] & ~sclk_q[1] & cs_low;

  // request in the clock of the 8th falling edge
  assign rd_req  = sclk_fall && (bit_cnt == ADDR_LAST);
  assign rd_addr = {shift_in[6:0], mosi_q[1]};

  ////////////////////////////////////////
  // frame engine

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bit_cnt   <= '0;
      shift_out <= '0;
      load_pend <= 1'b0;
    end
    else
    begin
      // bank reply is registered, load one clk later
      load_pend <= rd_req;
      if (cs_fall)
      begin
        bit_cnt   <= '0;
        shift_out <= '0;
      end
      else if (load_pend)
        shift_out <= rd_data;
      else if (sclk_fall)
      begin
        if (bit_cnt != CNT_MAX)
          bit_cnt <= bit_cnt + 1'b1;
        shift_out <= {shift_out[22:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sclk_fall)
      shift_in <= {shift_in[30:0], mosi_q[1]};
  end

  // write command on cs release
  always_ff @(posedge clk)
  begin
    if (rst)
      wr.valid <= 1'b0;
    else
    begin
      wr.valid <= cs_rise && (bit_cnt == FRAME_BITS) && !shift_in[NO_WR_POS];
      if (cs_rise)
      begin
        wr.addr <= shift_in[31:24];
        wr.data <= shift_in[23:0];
      end
    end
  end

  // raw cs gates miso, low as soon as the master lets go
  assign spi_miso = ~spi_cs & shift_out[23];

endmodule

`default_nettype wire

/* hw/msadc_top.sv */
////////////////////////////////////////
// single clock domain, spi pins oversampled by clk
////////////////////////////////////////
`default_nettype none

module msadc_top
  import msadc_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     cmp_out,
  input  logic     spi_cs,
  input  logic     spi_sclk,
  input  logic     spi_mosi,
  output logic     spi_miso,
  output logic     cmp_latch,
  output logic     irq_n,
  output int_sel_e int_sel
);

  conv_result_t result;
  logic         rd_req;
  reg_addr_t    rd_addr;
  reg_data_t    rd_data;
  reg_wr_t      wr;

  // conversion sequencer
  msadc_modulator u_modulator (
    .clk       (clk),
    .rst       (rst),
    .cmp_out   (cmp_out),
    .int_sel   (int_sel),
    .cmp_latch (cmp_latch),
    .irq_n     (irq_n),
    .result    (result)
  );

  // host interface
  msadc_spi_slave u_spi_slave (
    .clk      (clk),
    .rst      (rst),
    .spi_cs   (spi_cs),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .rd_req   (rd_req),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .wr       (wr)
  );

  msadc_reg_bank u_reg_bank (
    .clk     (clk),
    .rst     (rst),
    .result  (result),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr      (wr)
  );

endmodule

`default_nettype wire

/* verification/msadc_props.sv */
////////////////////////////////////////
// bound to msadc_top and sees only its ports
////////////////////////////////////////
`default_nettype none

module msadc_props
  import msadc_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     irq_n,
  input int_sel_e int_sel,
  input logic     spi_cs,
  input logic     spi_miso
);

  timeunit 1ns;
  timeprecision 1ps;

  // number of failed assertions so far
  int unsigned fail_count = 0;

  // interrupt is a single clock pulse
  a_irq_pulse: assert property (@(posedge clk) disable iff (rst) !irq_n |=> irq_n)
  else
  begin
    fail_count++;
    $error("irq_n low for more than one clock");
  end

  // integrator idle while the interrupt is pending
  a_irq_idle: assert property (@(posedge clk) disable iff (rst) !irq_n |-> int_sel == SEL_NONE)
  else
  begin
    fail_count++;
    $error("int_sel not idle during irq_n pulse");
  end

  a_miso_idle: assert property (@(posedge clk) disable iff (rst) spi_cs |-> !spi_miso)
  else
  begin
    fail_count++;
    $error("spi_miso driven while spi_cs is high");
  end

  // only the four switch codes are legal
  a_sel_legal: assert property (@(posedge clk) disable iff (rst)
    int_sel inside {SEL_NONE, SEL_POS, SEL_NEG, SEL_BOTH})
  else
  begin
    fail_count++;
    $error("undefined int_sel code");
  end

endmodule

bind msadc_top msadc_props u_props (
  .clk      (clk),
  .rst      (rst),
  .irq_n    (irq_n),
  .int_sel  (int_sel),
  .spi_cs   (spi_cs),
  .spi_miso (spi_miso)
);

`default_nettype wire

/* verification/msadc_tb.sv */
////////////////////////////////////////
// directed tests only, spi master runs sclk with a 4 clk half-period
// cmp_out models the comparator directly, there is no integrator model
////////////////////////////////////////
`default_nettype none

`include "msadc_settings.svh"

module msadc_tb
  import msadc_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  // rundown length forced by the comparator stimulus
  localparam int R_CLKS     = 30;
  localparam int CONV_CLKS  = `MSADC_INIT_CLKS
    + (`MSADC_INT_CYCLES + 1) * `MSADC_CYCLE_CLKS + 200;
  // one spi frame incl. cs setup and gap
  localparam int FRAME_CLKS = 300;
  localparam int TIMEOUT_NS = (4 * CONV_CLKS + 40 * FRAME_CLKS + 20) * 8;

  logic     clk = 1'b0;
  logic     rst;
  logic     cmp_out;
  logic     spi_cs;
  logic     spi_sclk;
  logic     spi_mosi;
  logic     spi_miso;
  logic     cmp_latch;
  logic     irq_n;
  int_sel_e int_sel;
  integer   seed = 32'h1894;

  msadc_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .cmp_out   (cmp_out),
    .spi_cs    (spi_cs),
    .spi_sclk  (spi_sclk),
    .spi_mosi  (spi_mosi),
    .spi_miso  (spi_miso),
    .cmp_latch (cmp_latch),
    .irq_n     (irq_n),
    .int_sel   (int_sel)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // helpers

  // inputs change 1 ns after the rising edge
  task automatic wait_clk;
    @(posedge clk);
    #1;
  endtask

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_sel(input string name, input int_sel_e got, input int_sel_e exp);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic reset_dut;
    rst = 1'b1;
    repeat (10) wait_clk;
    rst = 1'b0;
  endtask

  // one 32 bit frame with mosi changed after each rising edge
  // and miso sampled late in each high half
  task automatic spi_xfer(input reg_addr_t addr, input reg_data_t data,
                          output reg_data_t reply);
    logic [31:0] frame;
    integer      i;
    frame = {addr, data};
    reply = '0;
    spi_cs = 1'b0;
    repeat (4) wait_clk;
    for (i = 31; i >= 0; i = i - 1)
    begin
      repeat (4) wait_clk;
      spi_sclk = 1'b1;
      // slave takes this bit on the following falling edge
      spi_mosi = frame[i];
      repeat (4) wait_clk;
      // reply occupies the last 24 bits
      if (i < 24)
        reply = {reply[22:0], spi_miso};
      spi_sclk = 1'b0;
    end
    repeat (4) wait_clk;
    spi_cs = 1'b1;
    // gap covers the write command after cs release
    repeat (8) wait_clk;
  endtask

  // read-only frame, no-write bit set
  task automatic read_reg(input integer addr, output reg_data_t value);
    reg_addr_t a;
    a = reg_addr_t'(addr);
    a[`MSADC_NO_WRITE_BIT] = 1'b1;
    spi_xfer(a, '0, value);
  endtask

  task automatic write_reg(input integer addr, input reg_data_t value);
    reg_data_t unused;
    spi_xfer(reg_addr_t'(addr), value, unused);
  endtask

  // single clock pulse, sampled every clock
  task automatic wait_irq;
    while (irq_n !== 1'b0)
      wait_clk;
  endtask

  ////////////////////////////////////////
  // directed tests

  task automatic reset_outputs;
    check_sel("int_sel", int_sel, SEL_NONE);
    check_bit("irq_n", irq_n, 1'b1);
    check_bit("cmp_latch", cmp_latch, 1'b1);
    check_bit("spi_miso", spi_miso, 1'b0);
  endtask

  task automatic test_reg_access;
    reg_data_t value;
    reg_data_t got;
    integer    n;
    for (n = 0; n < 4; n = n + 1)
    begin
      value = reg_data_t'($random(seed));
      write_reg(`MSADC_ADDR_TEST, value);
      read_reg(`MSADC_ADDR_TEST, got);
      check_data("test_reg", got, value);
    end
    // data bits of a read-only frame must not land
    spi_xfer(reg_addr_t'(`MSADC_ADDR_TEST) | 8'h80, ~value, got);
    read_reg(`MSADC_ADDR_TEST, got);
    check_data("test_reg after read-only frame", got, value);
    read_reg(`MSADC_ADDR_ONES, got);
    check_data("ones", got, 24'hffffff);
    read_reg(3, got);
    check_data("unmapped", got, '0);
  endtask

  // also covers the phase length checks
  task automatic clean_conversion;
    int_sel_e  prev;
    integer    run_len;
    logic      first_pos;
    reg_data_t got;
    reset_dut;
    cmp_out = 1'b0;
    prev = int_sel;
    run_len = 0;
    first_pos = 1'b1;
    // measure each int_sel run until the rundown starts
    while (int_sel !== SEL_BOTH)
    begin
      wait_clk;
      if (int_sel === prev)
        run_len = run_len + 1;
      else
      begin
        if (prev == SEL_NEG)
          check_data("neg phase length", reg_data_t'(run_len),
                     reg_data_t'(`MSADC_FIX_CLKS + 2));
        if (prev == SEL_POS && first_pos)
        begin
          first_pos = 1'b0;
          if (run_len < `MSADC_FIX_CLKS + 2)
            stop_run($sformatf("first positive phase too short, %0d clocks", run_len));
        end
        prev = int_sel;
        run_len = 1;
      end
    end
    check_bit("cmp_latch", cmp_latch, 1'b0);
    // zero cross R clocks into the rundown
    repeat (R_CLKS) wait_clk;
    cmp_out = 1'b1;
    wait_irq;
    read_reg(`MSADC_ADDR_UP, got);
    check_data("up", got, '0);
    read_reg(`MSADC_ADDR_DOWN, got);
    check_data("down", got, reg_data_t'(2 * `MSADC_INT_CYCLES));
    read_reg(`MSADC_ADDR_TRANS_UP, got);
    check_data("trans_up", got, reg_data_t'(`MSADC_INT_CYCLES));
    read_reg(`MSADC_ADDR_TRANS_DOWN, got);
    check_data("trans_down", got, reg_data_t'(`MSADC_INT_CYCLES + 1));
    read_reg(`MSADC_ADDR_FLIP, got);
    check_data("flip", got, '0);
    read_reg(`MSADC_ADDR_RUNDOWN, got);
    if (got < R_CLKS || got > R_CLKS + 4)
      stop_run($sformatf("rundown count %h outside the expected window", got));
  endtask

  task automatic flip_conversion;
    reg_data_t got;
    reset_dut;
    cmp_out = 1'b1;
    while (int_sel === SEL_NONE)
      wait_clk;
    // release inside the extra variable phase
    repeat (`MSADC_INT_CYCLES * `MSADC_CYCLE_CLKS + `MSADC_VAR_CLKS / 2) wait_clk;
    cmp_out = 1'b0;
    while (int_sel !== SEL_BOTH)
      wait_clk;
    repeat (R_CLKS) wait_clk;
    cmp_out = 1'b1;
    wait_irq;
    read_reg(`MSADC_ADDR_UP, got);
    check_data("up", got, reg_data_t'(2 * `MSADC_INT_CYCLES + 1));
    read_reg(`MSADC_ADDR_DOWN, got);
    check_data("down", got, '0);
    read_reg(`MSADC_ADDR_TRANS_UP, got);
    check_data("trans_up", got, reg_data_t'(`MSADC_INT_CYCLES));
    read_reg(`MSADC_ADDR_TRANS_DOWN, got);
    check_data("trans_down", got, reg_data_t'(`MSADC_INT_CYCLES));
    read_reg(`MSADC_ADDR_FLIP, got);
    check_data("flip", got, 24'h1);
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog

  initial
  begin
    rst = 1'b1;
    cmp_out = 1'b0;
    spi_cs = 1'b1;
    spi_sclk = 1'b0;
    spi_mosi = 1'b0;
    reset_dut;
    reset_outputs;
    test_reg_access;
    clean_conversion;
    flip_conversion;
    if (u_dut.u_props.fail_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the tests completed");
    $display("Errors found");
    $fatal(1);
  end

endmodule

`default_nettype wire
